// ==== msix_bar.f ====
+incdir+bench
source/msix_pkg.sv
source/bar_write_decode.sv
source/msix_vector.sv
source/msix_issue.sv
source/bar_read_mux.sv
source/msix_bar.sv
bench/msix_bar_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the msix_bar testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module msix_bar_tb -f msix_bar.f -o msix_bar_sim \
    && ./obj_dir/msix_bar_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== bench/msix_bar_tests.svh ====
// ----------------------------------------------------------------------------
// table model and message helpers
// ----------------------------------------------------------------------------
function automatic logic [DATA_W-1:0] table_word(input logic [VEC_W-1:0] v,
                                                 input logic [1:0] word);
    case (word)
        WORD_ADDR_LO: return exp_addr[v][31:0];
        WORD_ADDR_HI: return exp_addr[v][63:32];
        WORD_DATA:    return exp_data[v];
        default:      return DATA_W'(exp_mask[v]);  // only the mask bit exists
    endcase
endfunction

task automatic table_write(input logic [VEC_W-1:0] v, input logic [1:0] word,
                           input logic [3:0] be, input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] cur;
    bus_write(TABLE_OFFSET + ADDR_W'({v, word, 2'b00}), be, d);
    cur = table_word(v, word);
    for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
            cur[8*b +: 8] = d[8*b +: 8];  // byte merge
        end
    end
    case (word)
        WORD_ADDR_LO: exp_addr[v][31:0]  = cur;
        WORD_ADDR_HI: exp_addr[v][63:32] = cur;
        WORD_DATA:    exp_data[v]        = cur;
        default: begin
            if (be[0]) begin
                exp_mask[v] = d[0];
            end
        end
    endcase
endtask

task automatic program_vector(input logic [VEC_W-1:0] v, input logic mask);
    table_write(v, WORD_ADDR_LO, 4'hF, take_bits(32));
    table_write(v, WORD_ADDR_HI, 4'hF, take_bits(32));
    table_write(v, WORD_DATA, 4'hF, take_bits(32));
    table_write(v, WORD_CTRL, 4'h1, 32'(mask));
endtask

task automatic trigger(input logic [VEC_W-1:0] v);
    bus_write(TRIGGER_OFFSET + ADDR_W'({v, 2'b00}), 4'hF, 32'h0);
endtask

task automatic wait_msgs(input int n);
    int waited;
    waited = 0;
    while (msg_addr_q.size() < n && waited < 20) begin
        idle(1);
        waited++;
    end
    if (msg_addr_q.size() < n) begin
        $display("error at %0t: waited for %0d messages, %0d arrived", $time, n,
                 msg_addr_q.size());
        errors++;
    end
endtask

task automatic expect_quiet(input int n);
    idle(n);
    if (msg_addr_q.size() != 0) begin
        $display("error at %0t: %0d unexpected messages", $time, msg_addr_q.size());
        errors++;
        msg_addr_q.delete();
        msg_data_q.delete();
        msg_cyc_q.delete();
    end
endtask

task automatic expect_msg(input logic [VEC_W-1:0] v, output int cyc);
    logic [MSG_ADDR_W-1:0] a;
    logic [DATA_W-1:0]     d;
    cyc = -1;
    if (msg_addr_q.size() == 0) begin
        $display("error at %0t: no message for vector %0d", $time, v);
        errors++;
    end else begin
        a   = msg_addr_q.pop_front();
        d   = msg_data_q.pop_front();
        cyc = msg_cyc_q.pop_front();
        if (a !== exp_addr[v])
            report_mismatch("msi_addr", a, exp_addr[v]);
        if (d !== exp_data[v])
            report_mismatch("msi_data", 64'(d), 64'(exp_data[v]));
    end
endtask

// ----------------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------------
task automatic reset_defaults();
    int e0;
    e0 = errors;
    // enable 0, function mask 1, size 15, next pointer 0, id 0x11
    read_check(CAP_OFFSET, (32'd1 << 30) | (32'd15 << 16) | 32'h11);
    for (int v = 0; v < NUM_VECTORS; v++) begin
        read_check(TABLE_OFFSET + ADDR_W'(16 * v + 12), 32'h1);
    end
    read_check(TABLE_OFFSET, 32'h0);
    read_check(PBA_OFFSET, 32'h0);
    read_check(32'h0000_4000, 32'h0);  // unmapped
    finish_test("reset defaults", e0);
endtask

task automatic table_storage();
    int                e0;
    logic [VEC_W-1:0]  v;
    logic [1:0]        word;
    logic [3:0]        be;
    logic [DATA_W-1:0] d;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
        v    = VEC_W'(take_bits(VEC_W));
        word = 2'(take_bits(2));
        be   = 4'(take_bits(4));
        d    = take_bits(32);
        if (word == WORD_CTRL) begin
            word = WORD_DATA;
        end
        table_write(v, word, be, d);
        read_check(TABLE_OFFSET + ADDR_W'({v, word, 2'b00}), table_word(v, word));
    end
    table_write(4'd7, WORD_CTRL, 4'hF, 32'hFFFF_FFFE);
    read_check(TABLE_OFFSET + ADDR_W'(16 * 7 + 12), 32'h0);
    table_write(4'd7, WORD_CTRL, 4'hF, 32'hA5A5_A5A5);  // upper bits dropped
    read_check(TABLE_OFFSET + ADDR_W'(16 * 7 + 12), 32'h1);
    bus_write(PBA_OFFSET, 4'hF, 32'hFFFF_FFFF);
    read_check(PBA_OFFSET, 32'h0);
    finish_test("table storage", e0);
endtask

task automatic trigger_while_disabled();
    int e0;
    int cyc;
    e0 = errors;
    program_vector(4'd5, 1'b1);
    trigger(4'd5);
    read_check(PBA_OFFSET, 32'h1 << 5);
    expect_quiet(10);
    table_write(4'd5, WORD_CTRL, 4'h1, 32'h0);
    bus_write(CAP_OFFSET, 4'h8, 32'h8000_0000);  // enable, function mask off
    wait_msgs(1);
    expect_msg(4'd5, cyc);
    return_credit();
    read_check(PBA_OFFSET, 32'h0);
    expect_quiet(5);
    finish_test("trigger while disabled", e0);
endtask

task automatic arbitration_and_masks();
    int e0;
    int cyc;
    e0 = errors;
    bus_write(CAP_OFFSET, 4'h8, 32'hC000_0000);  // hold issue off while arming
    program_vector(4'd3, 1'b0);
    program_vector(4'd9, 1'b0);
    program_vector(4'd12, 1'b1);
    trigger(4'd9);
    trigger(4'd3);
    trigger(4'd12);
    bus_write(CAP_OFFSET, 4'h8, 32'h8000_0000);
    wait_msgs(2);
    expect_msg(4'd3, cyc);
    expect_msg(4'd9, cyc);
    return_credit();
    return_credit();
    read_check(PBA_OFFSET, 32'h1 << 12);
    table_write(4'd12, WORD_CTRL, 4'h1, 32'h0);
    wait_msgs(1);
    expect_msg(4'd12, cyc);
    return_credit();
    // single trigger, nothing in the way
    trigger(4'd3);
    wait_msgs(1);
    expect_msg(4'd3, cyc);
    if (cyc != last_wr_cycle + 1) begin
        $display("error at %0t: message came %0d cycles after the trigger instead of 1",
                 $time, cyc - last_wr_cycle);
        errors++;
    end
    return_credit();
    finish_test("arbitration and masks", e0);
endtask

task automatic credit_flow();
    int               e0;
    int               cyc;
    logic [VEC_W-1:0] v;
    e0 = errors;
    bus_write(CAP_OFFSET, 4'h8, 32'hC000_0000);
    for (int i = 0; i < 6; i++) begin
        program_vector(VEC_W'(2 * i), 1'b0);
        trigger(VEC_W'(2 * i));
    end
    bus_write(CAP_OFFSET, 4'h8, 32'h8000_0000);
    wait_msgs(MSI_CREDITS);
    expect_msg(4'd0, cyc);
    expect_msg(4'd2, cyc);
    expect_quiet(10);
    read_check(PBA_OFFSET, 32'h0000_0550);  // vectors 4, 6, 8, 10 still waiting
    for (int i = 2; i < 6; i++) begin
        v = VEC_W'(2 * i);
        return_credit();
        wait_msgs(1);
        expect_msg(v, cyc);
        expect_quiet(3);
    end
    read_check(PBA_OFFSET, 32'h0);
    return_credit();
    return_credit();
    finish_test("credits", e0);
endtask

// ==== bench/msix_bar_tb.sv ====
module msix_bar_tb;
    import msix_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;  // the five tests need about 210

    logic                  clk = 1'b0;
    logic                  rst;
    logic [ADDR_W-1:0]     wr_addr;
    logic [3:0]            wr_be;
    logic [DATA_W-1:0]     wr_data;
    logic                  wr_valid;
    logic [CTX_W-1:0]      rd_req_ctx;
    logic [ADDR_W-1:0]     rd_req_addr;
    logic                  rd_req_valid;
    logic [CTX_W-1:0]      rd_rsp_ctx;
    logic [DATA_W-1:0]     rd_rsp_data;
    logic                  rd_rsp_valid;
    logic                  msi_valid;
    logic [MSG_ADDR_W-1:0] msi_addr;
    logic [DATA_W-1:0]     msi_data;
    logic                  msi_credit;

    int          cycles = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          last_wr_cycle = 0;
    int          rd_count = 0;
    logic [15:0] lfsr = 16'd82;

    // expected table contents
    logic [MSG_ADDR_W-1:0] exp_addr [NUM_VECTORS];
    logic [DATA_W-1:0]     exp_data [NUM_VECTORS];
    logic                  exp_mask [NUM_VECTORS];

    // message scoreboard
    logic [MSG_ADDR_W-1:0] msg_addr_q [$];
    logic [DATA_W-1:0]     msg_data_q [$];
    int                    msg_cyc_q [$];

    msix_bar u_msix_bar (
        .clk          (clk),
        .rst          (rst),
        .wr_addr      (wr_addr),
        .wr_be        (wr_be),
        .wr_data      (wr_data),
        .wr_valid     (wr_valid),
        .rd_req_ctx   (rd_req_ctx),
        .rd_req_addr  (rd_req_addr),
        .rd_req_valid (rd_req_valid),
        .rd_rsp_ctx   (rd_rsp_ctx),
        .rd_rsp_data  (rd_rsp_data),
        .rd_rsp_valid (rd_rsp_valid),
        .msi_valid    (msi_valid),
        .msi_addr     (msi_addr),
        .msi_data     (msi_data),
        .msi_credit   (msi_credit)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (msi_valid) begin
            msg_addr_q.push_back(msi_addr);
            msg_data_q.push_back(msi_data);
            msg_cyc_q.push_back(cycles);
        end
    end

    // ------------------------------------------------------------------------
    // stimulus helpers, each starts and ends 1 unit after a rising edge
    // ------------------------------------------------------------------------
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // galois step
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [3:0] be,
                             input logic [DATA_W-1:0] d);
        wr_addr  = addr;
        wr_be    = be;
        wr_data  = d;
        wr_valid = 1'b1;
        @(posedge clk);
        #1;
        wr_valid      = 1'b0;
        last_wr_cycle = cycles;  // edge that took the write
    endtask

    // reply is due exactly two edges after the request edge
    task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
        logic [CTX_W-1:0] ctx;
        ctx = {32'(rd_count), addr, 24'h5A_C3_96};
        rd_count++;
        rd_req_addr  = addr;
        rd_req_ctx   = ctx;
        rd_req_valid = 1'b1;
        idle(1);
        rd_req_valid = 1'b0;
        if (rd_rsp_valid !== 1'b0) begin
            $display("error at %0t: read response came one cycle early", $time);
            errors++;
        end
        if (rd_rsp_data !== '0)
            report_mismatch("rd_rsp_data", 64'(rd_rsp_data), 64'h0);
        idle(1);
        if (rd_rsp_valid !== 1'b1) begin
            $display("error at %0t: no read response two cycles after request to %h",
                     $time, addr);
            errors++;
        end
        if (rd_rsp_ctx !== ctx) begin
            $display("mismatch at %0t: rd_rsp_ctx got %h, expected %h", $time, rd_rsp_ctx, ctx);
            errors++;
        end
        if (rd_rsp_data !== exp)
            report_mismatch("rd_rsp_data", 64'(rd_rsp_data), 64'(exp));
    endtask

    task automatic return_credit();
        msi_credit = 1'b1;
        idle(1);
        msi_credit = 1'b0;
    endtask

    task automatic finish_test(input string name, input int e0);
        tests_run++;
        if (errors == e0) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - e0);
        end
    endtask

    `include "msix_bar_tests.svh"

    initial begin
        rst          = 1'b1;
        wr_addr      = '0;
        wr_be        = '0;
        wr_data      = '0;
        wr_valid     = 1'b0;
        rd_req_ctx   = '0;
        rd_req_addr  = '0;
        rd_req_valid = 1'b0;
        msi_credit   = 1'b0;
        for (int v = 0; v < NUM_VECTORS; v++) begin
            exp_addr[v] = '0;
            exp_data[v] = '0;
            exp_mask[v] = 1'b1;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_defaults();
        table_storage();
        trigger_while_disabled();
        arbitration_and_masks();
        credit_flow();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== source/msix_bar.sv ====
module msix_bar (
    input  logic                            clk,
    input  logic                            rst,
    // BAR writes
    input  logic [msix_pkg::ADDR_W-1:0]     wr_addr,
    input  logic [3:0]                      wr_be,
    input  logic [msix_pkg::DATA_W-1:0]     wr_data,
    input  logic                            wr_valid,
    // BAR reads
    input  logic [msix_pkg::CTX_W-1:0]      rd_req_ctx,
    input  logic [msix_pkg::ADDR_W-1:0]     rd_req_addr,
    input  logic                            rd_req_valid,
    output logic [msix_pkg::CTX_W-1:0]      rd_rsp_ctx,
    output logic [msix_pkg::DATA_W-1:0]     rd_rsp_data,
    output logic                            rd_rsp_valid,
    // messages to the TLP engine
    output logic                            msi_valid,
    output logic [msix_pkg::MSG_ADDR_W-1:0] msi_addr,
    output logic [msix_pkg::DATA_W-1:0]     msi_data,
    input  logic                            msi_credit
);
    import msix_pkg::*;

    logic [NUM_VECTORS-1:0]                 tab_wr;
    logic [1:0]                             tab_word;
    logic [3:0]                             tab_be;
    logic [DATA_W-1:0]                      tab_data;
    logic [NUM_VECTORS-1:0]                 trig;
    logic                                   msix_enable;
    logic                                   func_mask;
    logic [NUM_VECTORS-1:0][MSG_ADDR_W-1:0] vec_addr;
    logic [NUM_VECTORS-1:0][DATA_W-1:0]     vec_data;
    logic [NUM_VECTORS-1:0]                 vec_mask;
    logic [NUM_VECTORS-1:0]                 vec_pending;
    logic [NUM_VECTORS-1:0]                 vec_req;
    logic [NUM_VECTORS-1:0]                 grant;

    bar_write_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .wr_addr     (wr_addr),
        .wr_be       (wr_be),
        .wr_data     (wr_data),
        .wr_valid    (wr_valid),
        .tab_wr      (tab_wr),
        .tab_word    (tab_word),
        .tab_be      (tab_be),
        .tab_data    (tab_data),
        .trig        (trig),
        .msix_enable (msix_enable),
        .func_mask   (func_mask)
    );

    // ------------------------------------------------------------------------
    // vector table, one slot per entry
    // ------------------------------------------------------------------------
    for (genvar v = 0; v < NUM_VECTORS; v++) begin : g_vec
        msix_vector u_vec (
            .clk      (clk),
            .rst      (rst),
            .tab_wr   (tab_wr[v]),
            .tab_word (tab_word),
            .tab_be   (tab_be),
            .tab_data (tab_data),
            .trig     (trig[v]),
            .grant    (grant[v]),
            .addr     (vec_addr[v]),
            .data     (vec_data[v]),
            .mask     (vec_mask[v]),
            .pending  (vec_pending[v]),
            .req      (vec_req[v])
        );
    end

    msix_issue u_issue (
        .clk         (clk),
        .rst         (rst),
        .req         (vec_req),
        .vec_addr    (vec_addr),
        .vec_data    (vec_data),
        .msix_enable (msix_enable),
        .func_mask   (func_mask),
        .msi_credit  (msi_credit),
        .grant       (grant),
        .msi_valid   (msi_valid),
        .msi_addr    (msi_addr),
        .msi_data    (msi_data)
    );

    bar_read_mux u_read (
        .clk          (clk),
        .rd_req_ctx   (rd_req_ctx),
        .rd_req_addr  (rd_req_addr),
        .rd_req_valid (rd_req_valid),
        .msix_enable  (msix_enable),
        .func_mask    (func_mask),
        .vec_addr     (vec_addr),
        .vec_data     (vec_data),
        .vec_mask     (vec_mask),
        .vec_pending  (vec_pending),
        .rd_rsp_ctx   (rd_rsp_ctx),
        .rd_rsp_data  (rd_rsp_data),
        .rd_rsp_valid (rd_rsp_valid)
    );

endmodule

// ==== source/bar_read_mux.sv ====
module bar_read_mux (
    input  logic                                                      clk,
    input  logic [msix_pkg::CTX_W-1:0]                                rd_req_ctx,
    input  logic [msix_pkg::ADDR_W-1:0]                               rd_req_addr,
    input  logic                                                      rd_req_valid,
    input  logic                                                      msix_enable,
    input  logic                                                      func_mask,
    input  logic [msix_pkg::NUM_VECTORS-1:0][msix_pkg::MSG_ADDR_W-1:0] vec_addr,
    input  logic [msix_pkg::NUM_VECTORS-1:0][msix_pkg::DATA_W-1:0]     vec_data,
    input  logic [msix_pkg::NUM_VECTORS-1:0]                          vec_mask,
    input  logic [msix_pkg::NUM_VECTORS-1:0]                          vec_pending,
    output logic [msix_pkg::CTX_W-1:0]                                rd_rsp_ctx,
    output logic [msix_pkg::DATA_W-1:0]                               rd_rsp_data,
    output logic                                                      rd_rsp_valid
);
    import msix_pkg::*;

    logic [CTX_W-1:0]  ctx_1;
    logic [ADDR_W-1:0] addr_1;
    logic              valid_1;
    logic [DATA_W-1:0] ctrl_word;
    logic [DATA_W-1:0] rd_word;
    logic [VEC_W-1:0]  vec;

    // stage one, capture the request
    always_ff @(posedge clk) begin
        ctx_1   <= rd_req_ctx;
        addr_1  <= rd_req_addr;
        valid_1 <= rd_req_valid;
    end

    // ------------------------------------------------------------------------
    // word select
    // ------------------------------------------------------------------------
    always_comb begin
        ctrl_word                                  = '0;
        ctrl_word[ENABLE_BIT]                      = msix_enable;
        ctrl_word[FMASK_BIT]                       = func_mask;
        ctrl_word[TBL_SIZE_LSB +: TBL_SIZE_W]      = TBL_SIZE_W'(NUM_VECTORS - 1);
        ctrl_word[NEXT_PTR_LSB +: 8]               = CAP_NEXT_PTR;
        ctrl_word[7:0]                             = MSIX_CAP_ID;
    end

    assign vec = addr_1[4 +: VEC_W];

    always_comb begin
        rd_word = '0;  // unmapped reads as zero
        if (addr_1[ADDR_W-1:2] == CAP_OFFSET[ADDR_W-1:2]) begin
            rd_word = ctrl_word;
        end else if (((addr_1 & PAGE_MASK) == TABLE_OFFSET) && (addr_1[11:4+VEC_W] == '0)) begin
            case (addr_1[3:2])
                WORD_ADDR_LO: rd_word = vec_addr[vec][DATA_W-1:0];
                WORD_ADDR_HI: rd_word = vec_addr[vec][MSG_ADDR_W-1:DATA_W];
                WORD_DATA:    rd_word = vec_data[vec];
                default:      rd_word = DATA_W'(vec_mask[vec]);
            endcase
        end else if (((addr_1 & PAGE_MASK) == PBA_OFFSET) && (addr_1[11:2] == '0)) begin
            rd_word = DATA_W'(vec_pending);  // pending bits in the low half
        end
    end

    // stage two, the reply
    always_ff @(posedge clk) begin
        rd_rsp_ctx   <= ctx_1;
        rd_rsp_valid <= valid_1;
        rd_rsp_data  <= valid_1 ? rd_word : '0;
    end

endmodule

// ==== source/msix_issue.sv ====
module msix_issue (
    input  logic                                                      clk,
    input  logic                                                      rst,
    input  logic [msix_pkg::NUM_VECTORS-1:0]                          req,
    input  logic [msix_pkg::NUM_VECTORS-1:0][msix_pkg::MSG_ADDR_W-1:0] vec_addr,
    input  logic [msix_pkg::NUM_VECTORS-1:0][msix_pkg::DATA_W-1:0]     vec_data,
    input  logic                                                      msix_enable,
    input  logic                                                      func_mask,
    input  logic                                                      msi_credit,
    output logic [msix_pkg::NUM_VECTORS-1:0]                          grant,
    output logic                                                      msi_valid,
    output logic [msix_pkg::MSG_ADDR_W-1:0]                           msi_addr,
    output logic [msix_pkg::DATA_W-1:0]                               msi_data
);
    import msix_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic [VEC_W-1:0]    sel;
    logic                can_issue;
    logic                issue;

    // ------------------------------------------------------------------------
    // fixed priority, lowest index wins
    // ------------------------------------------------------------------------
    always_comb begin
        sel = '0;
        for (int i = NUM_VECTORS - 1; i >= 0; i--) begin
            if (req[i]) begin
                sel = VEC_W'(i);
            end
        end
    end

    assign can_issue = msix_enable && !func_mask && (credits != '0);
    assign issue     = can_issue && (|req);
    assign grant     = issue ? (NUM_VECTORS'(1) << sel) : '0;  // clears pending at this edge

    // message register
    always_ff @(posedge clk) begin
        if (rst) begin
            msi_valid <= 1'b0;
        end else begin
            msi_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            msi_addr <= vec_addr[sel];
            msi_data <= vec_data[sel];
        end
    end

    // credit counter, return and spend in one cycle cancel out
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(MSI_CREDITS);
        end else begin
            credits <= credits + CREDIT_W'(msi_credit) - CREDIT_W'(issue);
        end
    end

endmodule

// ==== source/msix_vector.sv ====
module msix_vector (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            tab_wr,
    input  logic [1:0]                      tab_word,
    input  logic [3:0]                      tab_be,
    input  logic [msix_pkg::DATA_W-1:0]     tab_data,
    input  logic                            trig,
    input  logic                            grant,
    output logic [msix_pkg::MSG_ADDR_W-1:0] addr,
    output logic [msix_pkg::DATA_W-1:0]     data,
    output logic                            mask,
    output logic                            pending,
    output logic                            req
);
    import msix_pkg::*;

    // table entry, byte-enabled update
    always_ff @(posedge clk) begin
        if (rst) begin
            addr <= '0;
            data <= '0;
            mask <= 1'b1;  // every vector starts masked
        end else if (tab_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (tab_be[b]) begin
                    case (tab_word)
                        WORD_ADDR_LO: addr[8*b +: 8]          <= tab_data[8*b +: 8];
                        WORD_ADDR_HI: addr[DATA_W+8*b +: 8]   <= tab_data[8*b +: 8];
                        WORD_DATA:    data[8*b +: 8]          <= tab_data[8*b +: 8];
                        default: ;    // control word handled below
                    endcase
                end
            end
            // vector control keeps only the mask bit
            if (tab_word == WORD_CTRL && tab_be[0]) begin
                mask <= tab_data[0];
            end
        end
    end

    // pending bit, a new trigger beats a grant in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (trig) begin
            pending <= 1'b1;
        end else if (grant) begin
            pending <= 1'b0;
        end
    end

    assign req = pending && !mask;

endmodule

// ==== source/bar_write_decode.sv ====
module bar_write_decode (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [msix_pkg::ADDR_W-1:0]      wr_addr,
    input  logic [3:0]                       wr_be,
    input  logic [msix_pkg::DATA_W-1:0]      wr_data,
    input  logic                             wr_valid,
    output logic [msix_pkg::NUM_VECTORS-1:0] tab_wr,
    output logic [1:0]                       tab_word,
    output logic [3:0]                       tab_be,
    output logic [msix_pkg::DATA_W-1:0]      tab_data,
    output logic [msix_pkg::NUM_VECTORS-1:0] trig,
    output logic                             msix_enable,
    output logic                             func_mask
);
    import msix_pkg::*;

    logic             table_hit;
    logic             trig_hit;
    logic             cap_hit;
    logic [VEC_W-1:0] tab_vec;
    logic [VEC_W-1:0] trig_vec;

    // ------------------------------------------------------------------------
    // page decode
    // ------------------------------------------------------------------------
    // only the first 16 entries of the table page exist
    assign table_hit = wr_valid && ((wr_addr & PAGE_MASK) == TABLE_OFFSET)
                       && (wr_addr[11:4+VEC_W] == '0);
    assign trig_hit  = wr_valid && ((wr_addr & PAGE_MASK) == TRIGGER_OFFSET);
    assign cap_hit   = wr_valid && (wr_addr[ADDR_W-1:2] == CAP_OFFSET[ADDR_W-1:2]);
    // pba page is read-only, nothing decodes it here

    assign tab_vec  = wr_addr[4 +: VEC_W];  // 16 bytes per entry
    assign trig_vec = wr_addr[2 +: VEC_W];  // one dword per vector

    // one-hot strobes towards the vector slots
    assign tab_wr   = table_hit ? (NUM_VECTORS'(1) << tab_vec) : '0;
    assign trig     = trig_hit ? (NUM_VECTORS'(1) << trig_vec) : '0;
    assign tab_word = wr_addr[3:2];
    assign tab_be   = wr_be;
    assign tab_data = wr_data;

    // ------------------------------------------------------------------------
    // message control register
    // ------------------------------------------------------------------------
    // only the top byte is writable, size and id are constants
    always_ff @(posedge clk) begin
        if (rst) begin
            msix_enable <= 1'b0;
            func_mask   <= 1'b1;  // masked until software sets it up
        end else if (cap_hit && wr_be[3]) begin
            msix_enable <= wr_data[ENABLE_BIT];
            func_mask   <= wr_data[FMASK_BIT];
        end
    end

endmodule

// ==== source/msix_pkg.sv ====
package msix_pkg;

    // ------------------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------------------
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int CTX_W      = 88;   // opaque completion context
    localparam int MSG_ADDR_W = 64;

    // vector table geometry
    localparam int NUM_VECTORS = 16;
    localparam int VEC_W       = 4;

    // ------------------------------------------------------------------------
    // BAR address map
    // ------------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] CAP_OFFSET     = 32'h0000_0110;
    localparam logic [ADDR_W-1:0] TABLE_OFFSET   = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] PBA_OFFSET     = 32'h0000_2000;
    localparam logic [ADDR_W-1:0] TRIGGER_OFFSET = 32'h0000_3000;
    localparam logic [ADDR_W-1:0] PAGE_MASK      = 32'hFFFF_F000;  // 4k page select

    // ------------------------------------------------------------------------
    // message control word layout
    // ------------------------------------------------------------------------
    localparam logic [7:0] MSIX_CAP_ID  = 8'h11;
    localparam logic [7:0] CAP_NEXT_PTR = 8'h00;  // end of capability list
    localparam int ENABLE_BIT   = 31;
    localparam int FMASK_BIT    = 30;
    localparam int TBL_SIZE_LSB = 16;
    localparam int TBL_SIZE_W   = 11;             // table size minus one
    localparam int NEXT_PTR_LSB = 8;

    // table entry words, 16 bytes per vector
    localparam logic [1:0] WORD_ADDR_LO = 2'd0;
    localparam logic [1:0] WORD_ADDR_HI = 2'd1;
    localparam logic [1:0] WORD_DATA    = 2'd2;
    localparam logic [1:0] WORD_CTRL    = 2'd3;

    // message credits towards the TLP engine
    localparam int MSI_CREDITS = 2;
    localparam int CREDIT_W    = $clog2(MSI_CREDITS + 1);

endpackage
